/* logic/snn_cfg_pkg.sv */
// SNN input tile geometry
// Sizes of the spike buffer, the pattern TCAM and their index fields

package snn_cfg_pkg;

    // ==================================================
    // Array geometry
    // ==================================================
    localparam int ROWS          = 8;   // TCAM rows per timestep
    localparam int SPIKES        = 16;  // Bits per spike pattern
    localparam int MAX_TIMESTEPS = 4;   // Buffer depth in timesteps

    // Index widths
    localparam int ROW_W = 3;  // Row select, log2 of ROWS
    localparam int TS_W  = 2;  // Timestep select, log2 of MAX_TIMESTEPS

    // Buffer address is timestep * ROWS + row,
    // so the timestep sits above the row bits
    localparam int BUF_AW = TS_W + ROW_W;

    // Total buffer words
    localparam int BUF_DEPTH = MAX_TIMESTEPS * ROWS;

endpackage

/* logic/snn_apb_pkg.sv */
// APB register map of the SNN input tile
// Offsets of the control registers and buffer window, plus
// the two ways a write data word is decoded

package snn_apb_pkg;

    // ==================================================
    // Bus geometry
    // ==================================================
    localparam int APB_AW = 12;
    localparam int APB_DW = 32;

    // ==================================================
    // Register offsets
    // ==================================================
    localparam logic [APB_AW-1:0] ADDR_CTRL     = 12'h000;  // Start bit + timestep
    localparam logic [APB_AW-1:0] ADDR_STATUS   = 12'h004;  // {done, busy}
    localparam logic [APB_AW-1:0] ADDR_QUERY    = 12'h008;  // Query pattern
    localparam logic [APB_AW-1:0] ADDR_MATCH    = 12'h00C;  // Match vector, RO
    localparam logic [APB_AW-1:0] ADDR_BUF_BASE = 12'h100;  // Word k at base + 4k

    // One bus word, seen either as a control word or a spike word
    typedef union packed {
        struct packed {
            logic                                   start;  // Bit 31
            logic [APB_DW-2-snn_cfg_pkg::TS_W:0]    rsvd;
            logic [snn_cfg_pkg::TS_W-1:0]           ts;     // Timestep to inject
        } ctrl;
        struct packed {
            logic [APB_DW-snn_cfg_pkg::SPIKES-1:0]  rsvd;   // Upper half unused
            logic [snn_cfg_pkg::SPIKES-1:0]         pattern;
        } spike;
    } apb_word_u;

endpackage

/* logic/spike_apb_regs.sv */
// APB register front end of the SNN input tile
// Decodes buffer, query and control writes, tracks busy/done
// and returns status, query and match on reads

`timescale 1ns/1ps

module spike_apb_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [snn_apb_pkg::APB_AW-1:0]      paddr,
    input  logic [snn_apb_pkg::APB_DW-1:0]      pwdata,
    output logic [snn_apb_pkg::APB_DW-1:0]      prdata,
    output logic                                buf_wr_en,
    output logic [snn_cfg_pkg::BUF_AW-1:0]      buf_wr_addr,
    output logic [snn_cfg_pkg::SPIKES-1:0]      buf_wr_data,
    output logic                                tile_start,
    output logic [snn_cfg_pkg::TS_W-1:0]        timestep_idx,
    input  logic                                inject_done,
    output logic                                query_wr,
    output logic [snn_cfg_pkg::SPIKES-1:0]      query_key,
    input  logic [snn_cfg_pkg::ROWS-1:0]        match_vec
);

    snn_apb_pkg::apb_word_u wr_word;         // pwdata, decoded by address
    logic                   setup_rd;        // Read setup phase
    logic                   access_wr;       // Write access phase
    logic                   in_buf;          // Address hits buffer window
    logic                   start_req;
    logic                   busy;
    logic                   done;
    logic [snn_cfg_pkg::SPIKES-1:0] query_q; // Readback copy of QUERY

    assign wr_word   = pwdata;
    assign setup_rd  = psel && !penable && !pwrite;
    assign access_wr = psel && penable && pwrite;

    // 128-byte window, compare the bits above the word index
    assign in_buf = paddr[snn_apb_pkg::APB_AW-1:snn_cfg_pkg::BUF_AW+2] ==
        snn_apb_pkg::ADDR_BUF_BASE[snn_apb_pkg::APB_AW-1:snn_cfg_pkg::BUF_AW+2];

    // ==================================================
    // Write decode
    // ==================================================
    assign buf_wr_en   = access_wr && in_buf;
    assign buf_wr_addr = paddr[snn_cfg_pkg::BUF_AW+1:2];     // Byte to word address
    assign buf_wr_data = wr_word.spike.pattern;

    assign query_wr  = access_wr && (paddr == snn_apb_pkg::ADDR_QUERY);
    assign query_key = wr_word.spike.pattern;

    assign start_req = access_wr && (paddr == snn_apb_pkg::ADDR_CTRL)
                       && wr_word.ctrl.start;

    // Start pulse and busy/done tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tile_start   <= 1'b0;
            timestep_idx <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
            query_q      <= '0;
        end else begin
            tile_start <= 1'b0;                  // Single-cycle pulse
            if (start_req && !busy) begin        // Dropped while busy
                tile_start   <= 1'b1;
                timestep_idx <= wr_word.ctrl.ts;
                busy         <= 1'b1;
                done         <= 1'b0;            // Sticky bit cleared on start
            end else if (inject_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (query_wr)
                query_q <= query_key;
        end
    end

    // ==================================================
    // Read path, valid in the access cycle
    // ==================================================
    always_ff @(posedge clk) begin
        if (setup_rd) begin
            case (paddr)
                snn_apb_pkg::ADDR_STATUS:
                    prdata <= {{(snn_apb_pkg::APB_DW-2){1'b0}}, done, busy};
                snn_apb_pkg::ADDR_QUERY:
                    prdata <= {{(snn_apb_pkg::APB_DW-snn_cfg_pkg::SPIKES){1'b0}}, query_q};
                snn_apb_pkg::ADDR_MATCH:
                    prdata <= {{(snn_apb_pkg::APB_DW-snn_cfg_pkg::ROWS){1'b0}}, match_vec};
                default:
                    prdata <= '0;                // CTRL, buffer, unmapped
            endcase
        end
    end

    // The injector must never see a second start mid-run
    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        tile_start |-> !$past(busy));

endmodule

/* logic/spike_injector.sv */
// Spike injector
// Buffers spike patterns for every timestep and, on tile_start,
// streams the selected timestep's rows into the pattern TCAM

`timescale 1ns/1ps

module spike_injector (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                tile_start,
    input  logic [snn_cfg_pkg::TS_W-1:0]        timestep_idx,
    output logic                                inject_done,
    input  logic                                buf_wr_en,
    input  logic [snn_cfg_pkg::BUF_AW-1:0]      buf_wr_addr,
    input  logic [snn_cfg_pkg::SPIKES-1:0]      buf_wr_data,
    output logic                                tcam_set_en,
    output logic [snn_cfg_pkg::ROW_W-1:0]       tcam_set_addr,
    output logic [snn_cfg_pkg::SPIKES-1:0]      tcam_set_key
);

    // FSM encoding
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_LOAD = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [snn_cfg_pkg::SPIKES-1:0] spike_buf [snn_cfg_pkg::BUF_DEPTH];
    logic [1:0]                     state;
    logic [snn_cfg_pkg::ROW_W-1:0]  row_cnt;
    logic [snn_cfg_pkg::TS_W-1:0]   ts_q;      // Timestep under injection
    logic [snn_cfg_pkg::BUF_AW-1:0] rd_addr;
    logic [snn_cfg_pkg::ROW_W-1:0]  addr_next; // For the ordering check

    // timestep * ROWS + row, ROWS is a power of two
    assign rd_addr   = {ts_q, row_cnt};
    assign addr_next = tcam_set_addr + 1'b1;

    // ==================================================
    // Spike buffer
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < snn_cfg_pkg::BUF_DEPTH; i++)
                spike_buf[i] <= '0;
        end else if (buf_wr_en) begin
            spike_buf[buf_wr_addr] <= buf_wr_data;   // Host may write any time
        end
    end

    // ==================================================
    // Sequencer
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            row_cnt     <= '0;
            ts_q        <= '0;
            inject_done <= 1'b0;
            tcam_set_en <= 1'b0;
        end else begin
            tcam_set_en <= 1'b0;
            inject_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (tile_start) begin
                        ts_q    <= timestep_idx;     // Hold for the whole run
                        row_cnt <= '0;
                        state   <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    tcam_set_en <= 1'b1;             // One row per cycle
                    row_cnt     <= row_cnt + 1'b1;
                    if (int'(row_cnt) == snn_cfg_pkg::ROWS - 1)
                        state <= ST_DONE;
                end
                ST_DONE: begin
                    inject_done <= 1'b1;
                    state       <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Row payload, follows tcam_set_en
    always_ff @(posedge clk) begin
        if (state == ST_LOAD) begin
            tcam_set_addr <= row_cnt;
            tcam_set_key  <= spike_buf[rd_addr];
        end
    end

    // Writes only come out of the load phase
    a_set_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        tcam_set_en |-> $past(state) == ST_LOAD);

    // Back-to-back writes walk the rows in order
    a_set_addr_inc: assert property (@(posedge clk) disable iff (!rst_n)
        tcam_set_en && $past(tcam_set_en) |-> tcam_set_addr == $past(addr_next));

endmodule

/* logic/pattern_tcam.sv */
// Pattern TCAM for product sparsity
// Holds one spike pattern per row and reports which nonzero rows
// are a subset of the query pattern

`timescale 1ns/1ps

module pattern_tcam (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                tcam_set_en,
    input  logic [snn_cfg_pkg::ROW_W-1:0]       tcam_set_addr,
    input  logic [snn_cfg_pkg::SPIKES-1:0]      tcam_set_key,
    input  logic                                query_wr,
    input  logic [snn_cfg_pkg::SPIKES-1:0]      query_key,
    output logic [snn_cfg_pkg::ROWS-1:0]        match_vec
);

    logic [snn_cfg_pkg::SPIKES-1:0] rows [snn_cfg_pkg::ROWS];
    logic [snn_cfg_pkg::SPIKES-1:0] query_q;
    logic                           match_pend;   // Query loaded last cycle
    logic [snn_cfg_pkg::ROWS-1:0]   hit;

    // ==================================================
    // Row storage and query register
    // ==================================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < snn_cfg_pkg::ROWS; r++)
                rows[r] <= '0;
            query_q    <= '0;
            match_pend <= 1'b0;
        end else begin
            if (tcam_set_en)
                rows[tcam_set_addr] <= tcam_set_key;
            if (query_wr)
                query_q <= query_key;
            match_pend <= query_wr;
        end
    end

    // Subset test per row
    always_comb begin
        for (int r = 0; r < snn_cfg_pkg::ROWS; r++) begin
            // Empty rows never match
            hit[r] = (|rows[r]) && ((rows[r] & ~query_q) == '0);
        end
    end

    // Result only updates on a new query, not on row writes
    always_ff @(posedge clk) begin
        if (!rst_n)
            match_vec <= '0;
        else if (match_pend)
            match_vec <= hit;
    end

    // Injector row index stays inside the array
    a_set_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        tcam_set_en |-> int'(tcam_set_addr) < snn_cfg_pkg::ROWS);

endmodule

/* logic/snn_inject_top.sv */
// SNN input tile top level
// APB front end -> spike injector -> pattern TCAM, with the match
// vector returned to the front end for host reads

`timescale 1ns/1ps

module snn_inject_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [snn_apb_pkg::APB_AW-1:0]  paddr,
    input  logic [snn_apb_pkg::APB_DW-1:0]  pwdata,
    output logic [snn_apb_pkg::APB_DW-1:0]  prdata
);

    // Front end to injector
    logic                           buf_wr_en;
    logic [snn_cfg_pkg::BUF_AW-1:0] buf_wr_addr;
    logic [snn_cfg_pkg::SPIKES-1:0] buf_wr_data;
    logic                           tile_start;
    logic [snn_cfg_pkg::TS_W-1:0]   timestep_idx;
    logic                           inject_done;

    // Injector to TCAM
    logic                           tcam_set_en;
    logic [snn_cfg_pkg::ROW_W-1:0]  tcam_set_addr;
    logic [snn_cfg_pkg::SPIKES-1:0] tcam_set_key;

    // Front end and TCAM
    logic                           query_wr;
    logic [snn_cfg_pkg::SPIKES-1:0] query_key;
    logic [snn_cfg_pkg::ROWS-1:0]   match_vec;

    spike_apb_regs i_regs (.*);

    spike_injector i_injector (.*);

    pattern_tcam i_tcam (.*);

endmodule

/* sim/tb_snn_inject.sv */
// Testbench for the SNN input tile
// Loads spike patterns over APB, runs injections and checks the
// TCAM match vector against a subset model of the spike buffer

`timescale 1ns/1ps

module tb_snn_inject;

    localparam int RUN_SEED  = 32'h895d_4d91;
    localparam int MAX_POLLS = 50;          // STATUS polls per injection

    logic                               clk;
    logic                               rst_n;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [snn_apb_pkg::APB_AW-1:0]     paddr;
    logic [snn_apb_pkg::APB_DW-1:0]     pwdata;
    logic [snn_apb_pkg::APB_DW-1:0]     prdata;

    // Mirror of the spike buffer (zero after reset)
    logic [snn_cfg_pkg::SPIKES-1:0] model_buf [snn_cfg_pkg::BUF_DEPTH];

    snn_inject_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;             // 40 ns period
    end

    // ==================================================
    // Failure reporting and checks
    // ==================================================
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else
            abort_run($sformatf("ERROR: %s expected 0x%08h got 0x%08h", name, exp, got));
    endtask

    // ==================================================
    // APB transfers with one idle cycle after each
    // ==================================================
    task automatic apb_write(input logic [snn_apb_pkg::APB_AW-1:0] addr,
                             input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;                     // Setup
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;                     // Access cycle ends with the write
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [snn_apb_pkg::APB_AW-1:0] addr,
                            output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data    = prdata;                   // Held since end of setup
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Sparse pattern of about four spikes
    function automatic logic [snn_cfg_pkg::SPIKES-1:0] rand_pattern();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom();
        b = $urandom();
        return a[snn_cfg_pkg::SPIKES-1:0] & b[snn_cfg_pkg::SPIKES-1:0];
    endfunction

    // A nonzero row matches when no spike lies outside the query
    function automatic logic [snn_cfg_pkg::ROWS-1:0] expected_match(
        input int ts, input logic [snn_cfg_pkg::SPIKES-1:0] query);
        logic [snn_cfg_pkg::ROWS-1:0]   vec;
        logic [snn_cfg_pkg::SPIKES-1:0] row_pat;
        vec = '0;
        for (int r = 0; r < snn_cfg_pkg::ROWS; r++) begin
            row_pat = model_buf[ts * snn_cfg_pkg::ROWS + r];
            vec[r]  = (row_pat != '0) && ((row_pat & ~query) == '0);
        end
        return vec;
    endfunction

    task automatic write_pattern(input int ts, input int row, input logic [15:0] pat);
        snn_apb_pkg::apb_word_u w;
        int k;
        k = ts * snn_cfg_pkg::ROWS + row;
        w = '0;
        w.spike.pattern = pat;
        apb_write(snn_apb_pkg::ADDR_BUF_BASE + 12'(k * 4), w);
        model_buf[k] = pat;                 // Keep the model in step
    endtask

    task automatic start_timestep(input int ts);
        snn_apb_pkg::apb_word_u w;
        w = '0;
        w.ctrl.start = 1'b1;
        w.ctrl.ts    = ts[snn_cfg_pkg::TS_W-1:0];
        apb_write(snn_apb_pkg::ADDR_CTRL, w);
    endtask

    task automatic wait_done();
        logic [31:0] status;
        int polls;
        status = '0;
        polls  = 0;
        while (!status[1] && polls < MAX_POLLS) begin
            apb_read(snn_apb_pkg::ADDR_STATUS, status);
            polls++;
        end
        if (!status[1])
            abort_run("Injection never finished: done bit not set after 50 STATUS polls");
        else
            check_equal("prdata (STATUS)", 32'h2, status);  // Done and not busy
    endtask

    task automatic query_and_compare(input int ts, input logic [15:0] query);
        snn_apb_pkg::apb_word_u w;
        logic [31:0] rd;
        w = '0;
        w.spike.pattern = query;
        apb_write(snn_apb_pkg::ADDR_QUERY, w);
        apb_read(snn_apb_pkg::ADDR_MATCH, rd);   // Idle cycle covers the match latency
        check_equal("prdata (MATCH)", 32'(expected_match(ts, query)), rd);
    endtask

    // Query built from two stored rows plus stray spikes
    task automatic random_query_sweep(input int ts, input int count);
        logic [31:0] r;
        logic [15:0] query;
        for (int i = 0; i < count; i++) begin
            r = $urandom();
            query = model_buf[ts * snn_cfg_pkg::ROWS + int'(r[2:0])]
                  | model_buf[ts * snn_cfg_pkg::ROWS + int'(r[5:3])]
                  | (r[31:16] & r[23:8]);
            query_and_compare(ts, query);
        end
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic reset_state_reads_zero();
        logic [31:0] rd;
        logic [15:0] last_query;
        apb_read(snn_apb_pkg::ADDR_STATUS, rd);
        check_equal("prdata (STATUS)", 32'h0, rd);
        query_and_compare(0, 16'hFFFF);     // Empty TCAM matches nothing
        last_query = rand_pattern();
        query_and_compare(2, last_query);
        apb_read(snn_apb_pkg::ADDR_QUERY, rd);
        check_equal("prdata (QUERY)", {16'h0, last_query}, rd);
    endtask

    task automatic inject_random_timestep();
        for (int ts = 0; ts < snn_cfg_pkg::MAX_TIMESTEPS; ts++)
            for (int r = 0; r < snn_cfg_pkg::ROWS; r++)
                write_pattern(ts, r, rand_pattern());
        start_timestep(2);
        wait_done();
        random_query_sweep(2, 12);
    endtask

    task automatic zero_rows_never_match();
        logic [7:0]  zero_rows;
        logic [31:0] rd;
        zero_rows = 8'b0101_0010;           // Rows 1, 4, 6 empty
        for (int r = 0; r < snn_cfg_pkg::ROWS; r++)
            write_pattern(0, r, zero_rows[r] ? 16'h0 : (rand_pattern() | 16'h0001));
        start_timestep(0);
        wait_done();
        query_and_compare(0, 16'hFFFF);
        apb_read(snn_apb_pkg::ADDR_MATCH, rd);
        check_equal("prdata (MATCH)", {24'h0, ~zero_rows}, rd);  // Exactly the nonzero rows
    endtask

    task automatic start_while_busy_ignored();
        logic [31:0] rd;
        start_timestep(1);
        start_timestep(3);                  // Dropped while the injector is busy
        apb_read(snn_apb_pkg::ADDR_STATUS, rd);
        check_equal("prdata (STATUS)", 32'h1, rd);  // Done cleared by the start
        wait_done();
        random_query_sweep(1, 8);
    endtask

    task automatic buffer_rewrite_during_run();
        start_timestep(0);
        for (int r = 0; r < snn_cfg_pkg::ROWS; r++)
            write_pattern(3, r, rand_pattern() ^ 16'h0810);
        wait_done();
        query_and_compare(0, 16'hFFFF);
        start_timestep(3);
        wait_done();
        random_query_sweep(3, 10);
    endtask

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rst_n   = 1'b0;
        for (int i = 0; i < snn_cfg_pkg::BUF_DEPTH; i++)
            model_buf[i] = '0;
        void'($urandom(RUN_SEED));          // Seed once
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        reset_state_reads_zero();
        inject_random_timestep();
        zero_rows_never_match();
        start_while_busy_ignored();
        buffer_rewrite_during_run();

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* flist.f */
logic/snn_cfg_pkg.sv
logic/snn_apb_pkg.sv
logic/spike_apb_regs.sv
logic/spike_injector.sv
logic/pattern_tcam.sv
logic/snn_inject_top.sv
sim/tb_snn_inject.sv

/* run.sh */
#!/bin/sh
# Build and run the SNN input tile testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f flist.f --top-module tb_snn_inject -o sim_snn_inject

./obj_dir/sim_snn_inject 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
